//--- design/cov_counter_bank.sv
// One saturating hit counter per coverage bin, read combinationally
// An event bumps its op bin and every flagged event bin in the same cycle
`default_nettype none

`include "insn_cov_params.svh"

module cov_counter_bank import insn_cov_pkg::*; #(
  parameter int CNT_W = `INSN_COV_CNT_W
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  cov_event_t       evt_i,
  input  cov_bin_e         cnt_sel_i,
  output logic [CNT_W-1:0] cnt_o
);

  logic [CNT_W-1:0]              cnt_q [`INSN_COV_NUM_BINS];
  logic [`INSN_COV_NUM_BINS-1:0] hit;

  always_comb begin
    hit = '0;
    if (evt_i.valid) begin
      hit[evt_i.op]       = 1'b1;
      hit[BIN_ZERO_DST]   = evt_i.zero_dst;
      hit[BIN_SAME_SRC]   = evt_i.same_src;
      hit[BIN_ZERO_SRC]   = evt_i.zero_src;
      hit[BIN_RAW]        = evt_i.raw;
      hit[BIN_BR_BACK]    = evt_i.br_back;
      hit[BIN_BR_FWD]     = evt_i.br_fwd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `INSN_COV_NUM_BINS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `INSN_COV_NUM_BINS; i++) begin
        // Hold at all ones
        if (hit[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign cnt_o = (cnt_sel_i < `INSN_COV_NUM_BINS) ? cnt_q[cnt_sel_i] : '0;

  for (genvar g = 0; g < `INSN_COV_NUM_BINS; g++) begin : g_sat_check
    a_no_wrap: assert property (@(posedge clk_i) disable iff (reset_i)
      (cnt_q[g] == '1) |=> (cnt_q[g] != '0));
  end

endmodule

`default_nettype wire

//--- design/hazard_tracker.sv
// Forms one coverage event per decoded instruction, one cycle of latency
// RAW looks back at the previous valid retirement, idle cycles do not break it
`default_nettype none

module hazard_tracker import insn_cov_pkg::*; (
  input  logic          clk_i,
  input  logic          reset_i,
  input  decoded_insn_t dec_i,
  output cov_event_t    evt_o
);

  decoded_insn_t prev_q;
  logic          is_rtype;
  logic          is_store;
  logic          is_jal;
  logic          reads_rs;
  logic          raw_hit;
  cov_event_t    evt_d;

  // Op class from bin order
  assign is_rtype = (dec_i.op <= BIN_AND);
  assign is_jal   = (dec_i.op == BIN_JAL);
  assign is_store = (dec_i.op == BIN_SB) || (dec_i.op == BIN_SH) ||
                    (dec_i.op == BIN_SW);
  assign reads_rs = is_rtype || is_store;

  // Writes to x0 still count as a producer
  assign raw_hit = reads_rs && prev_q.valid && prev_q.writes_rd &&
                   ((prev_q.rd == dec_i.rs1) || (prev_q.rd == dec_i.rs2));

  always_comb begin
    evt_d.valid    = dec_i.valid;
    evt_d.op       = dec_i.op;
    evt_d.zero_dst = (is_rtype || is_jal) && (dec_i.rd == 5'd0);
    evt_d.same_src = reads_rs && (dec_i.rs1 == dec_i.rs2);
    evt_d.zero_src = reads_rs && ((dec_i.rs1 == 5'd0) || (dec_i.rs2 == 5'd0));
    evt_d.raw      = raw_hit;
    evt_d.raw_op   = raw_hit ? prev_q.op : BIN_OTHER;
    evt_d.br_back  = is_jal && dec_i.imm_neg;
    evt_d.br_fwd   = is_jal && !dec_i.imm_neg;
  end

  // Previous instruction, BIN_OTHER included
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prev_q.valid <= 1'b0;
    end else if (dec_i.valid) begin
      prev_q <= dec_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      evt_o.valid <= 1'b0;
    end else begin
      evt_o <= evt_d;
    end
  end

  a_jal_dir_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    evt_o.valid |-> !(evt_o.br_back && evt_o.br_fwd));

  // A hazard needs a consumer and a recorded producer
  a_raw_consumer: assert property (@(posedge clk_i) disable iff (reset_i)
    (evt_o.valid && evt_o.raw) |->
      ((evt_o.op <= BIN_AND) || (evt_o.op == BIN_SB) ||
       (evt_o.op == BIN_SH) || (evt_o.op == BIN_SW)) &&
      (evt_o.raw_op <= BIN_JAL));

endmodule

`default_nettype wire

//--- design/insn_cov_monitor.sv
// Instruction coverage monitor for a retire stream without back-pressure
// Event two cycles after retirement, counted on the edge after that
`default_nettype none

`include "insn_cov_params.svh"

module insn_cov_monitor import insn_cov_pkg::*; #(
  parameter int CNT_W = `INSN_COV_CNT_W
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      retire_valid_i,
  input  logic [`INSN_COV_XLEN-1:0] retire_insn_i,
  output cov_event_t                cov_event_o,
  input  cov_bin_e                  cnt_sel_i,
  output logic [CNT_W-1:0]          cnt_o
);

  decoded_insn_t dec;
  cov_event_t    evt;

  insn_decoder i_decoder (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .retire_valid_i (retire_valid_i),
    .retire_insn_i  (retire_insn_i),
    .dec_o          (dec)
  );

  hazard_tracker i_hazard (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .dec_i   (dec),
    .evt_o   (evt)
  );

  cov_counter_bank #(
    .CNT_W (CNT_W)
  ) i_counters (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .evt_i     (evt),
    .cnt_sel_i (cnt_sel_i),
    .cnt_o     (cnt_o)
  );

  assign cov_event_o = evt;

endmodule

`default_nettype wire

//--- design/insn_cov_params.svh
// Widths and bin count shared by the coverage monitor RTL
// INSN_COV_NUM_BINS must match the number of members in cov_bin_e
`ifndef INSN_COV_PARAMS_SVH
`define INSN_COV_PARAMS_SVH

// RV32 instruction word
`define INSN_COV_XLEN 32

// Default hit counter width, overridable at the top level
`define INSN_COV_CNT_W 16

`define INSN_COV_NUM_BINS 21

`endif

//--- design/insn_cov_pkg.sv
// Types for the instruction coverage monitor
// Op bins come first in cov_bin_e, event bins after them
`default_nettype none

package insn_cov_pkg;

  // Major opcodes that get their own classification
  typedef enum logic [6:0] {
    OPC_OP    = 7'b0110011,
    OPC_JAL   = 7'b1101111,
    OPC_STORE = 7'b0100011
  } opcode_e;

  typedef enum logic [4:0] {
    // Op bins
    BIN_ADD,
    BIN_SUB,
    BIN_SLL,
    BIN_SLT,
    BIN_SLTU,
    BIN_XOR,
    BIN_SRL,
    BIN_SRA,
    BIN_OR,
    BIN_AND,
    BIN_JAL,
    BIN_SB,
    BIN_SH,
    BIN_SW,
    BIN_OTHER,
    // Event bins
    BIN_ZERO_DST,
    BIN_SAME_SRC,
    BIN_ZERO_SRC,
    BIN_RAW,
    BIN_BR_BACK,
    BIN_BR_FWD
  } cov_bin_e;

  // One retired instruction after classification
  typedef struct packed {
    logic       valid;
    cov_bin_e   op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       imm_neg;
    logic       writes_rd;
  } decoded_insn_t;

  // Coverage hits for one retirement
  typedef struct packed {
    logic     valid;
    cov_bin_e op;
    logic     zero_dst;
    logic     same_src;
    logic     zero_src;
    logic     raw;
    cov_bin_e raw_op;   // BIN_OTHER when raw is clear
    logic     br_back;
    logic     br_fwd;
  } cov_event_t;

endpackage

`default_nettype wire

//--- design/insn_decoder.sv
// Classifies one retired RV32 instruction per cycle, one cycle of latency
// Unrecognised encodings decode to BIN_OTHER with writes_rd clear
`default_nettype none

`include "insn_cov_params.svh"

module insn_decoder import insn_cov_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      retire_valid_i,
  input  logic [`INSN_COV_XLEN-1:0] retire_insn_i,
  output decoded_insn_t             dec_o
);

  logic [6:0]    opcode;
  logic [6:0]    funct7;
  logic [2:0]    funct3;
  cov_bin_e      op_bin;
  logic          writes_rd;
  decoded_insn_t dec_d;

  assign opcode = retire_insn_i[6:0];
  assign funct7 = retire_insn_i[31:25];
  assign funct3 = retire_insn_i[14:12];

  always_comb begin
    op_bin = BIN_OTHER;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'd0:    op_bin = BIN_ADD;
            3'd1:    op_bin = BIN_SLL;
            3'd2:    op_bin = BIN_SLT;
            3'd3:    op_bin = BIN_SLTU;
            3'd4:    op_bin = BIN_XOR;
            3'd5:    op_bin = BIN_SRL;
            3'd6:    op_bin = BIN_OR;
            default: op_bin = BIN_AND;
          endcase
        end else if (funct7 == 7'b0100000) begin
          case (funct3)
            3'd0:    op_bin = BIN_SUB;
            3'd5:    op_bin = BIN_SRA;
            default: op_bin = BIN_OTHER;
          endcase
        end
      end
      OPC_JAL: op_bin = BIN_JAL;
      OPC_STORE: begin
        case (funct3)
          3'd0:    op_bin = BIN_SB;
          3'd1:    op_bin = BIN_SH;
          3'd2:    op_bin = BIN_SW;
          default: op_bin = BIN_OTHER;
        endcase
      end
      default: op_bin = BIN_OTHER;
    endcase
    // R-type ops occupy the lowest bins
    writes_rd = (op_bin <= BIN_AND) || (op_bin == BIN_JAL);
  end

  always_comb begin
    dec_d.valid     = retire_valid_i;
    dec_d.op        = op_bin;
    dec_d.rd        = retire_insn_i[11:7];
    dec_d.rs1       = retire_insn_i[19:15];
    dec_d.rs2       = retire_insn_i[24:20];
    dec_d.imm_neg   = retire_insn_i[31];
    dec_d.writes_rd = writes_rd;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o <= dec_d;
    end
  end

  a_dec_valid_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    1'b1 |=> (dec_o.valid == $past(retire_valid_i)));

endmodule

`default_nettype wire

//--- insn_cov.f
+incdir+design
design/insn_cov_pkg.sv
design/insn_decoder.sv
design/hazard_tracker.sv
design/cov_counter_bank.sv
design/insn_cov_monitor.sv
verification/tb_insn_cov_monitor.sv

//--- verification/tb_insn_cov_monitor.sv
// Self-checking testbench for the coverage monitor, counters built 6 bits wide
// Expects each event 2 cycles after its retirement and no event without one
`default_nettype none

`include "insn_cov_params.svh"

module tb_insn_cov_monitor import insn_cov_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CNT_W        = 6;
  localparam int CNT_MAX      = (1 << CNT_W) - 1;
  localparam int NUM_BINS     = `INSN_COV_NUM_BINS;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_RETIRES = 600;
  // Random phase at 70% valid takes about 860 cycles, readouts one cycle per bin
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_BINS + 64 +
                                  (RAND_RETIRES * 3) / 2 + 100;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      retire_valid;
  logic [`INSN_COV_XLEN-1:0] retire_insn;
  cov_bin_e                  cnt_sel;
  cov_event_t                cov_event;
  logic [CNT_W-1:0]          cnt;

  integer        seed = 21;
  int            errors = 0;
  int            cyc = 0;
  int            run_cycles = 0;
  cov_event_t    exp_q [$];
  int            cyc_q [$];
  int            model_cnt [NUM_BINS];
  decoded_insn_t model_prev;
  cov_event_t    want_evt;
  int            want_cyc;

  insn_cov_monitor #(
    .CNT_W (CNT_W)
  ) i_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .retire_valid_i (retire_valid),
    .retire_insn_i  (retire_insn),
    .cov_event_o    (cov_event),
    .cnt_sel_i      (cnt_sel),
    .cnt_o          (cnt)
  );

  always #20 clk = ~clk;

  function automatic cov_bin_e classify(input logic [31:0] insn);
    cov_bin_e op;
    op = BIN_OTHER;
    if (insn[6:0] == 7'b0110011) begin
      if (insn[31:25] == 7'b0000000) begin
        case (insn[14:12])
          3'd0: op = BIN_ADD;
          3'd1: op = BIN_SLL;
          3'd2: op = BIN_SLT;
          3'd3: op = BIN_SLTU;
          3'd4: op = BIN_XOR;
          3'd5: op = BIN_SRL;
          3'd6: op = BIN_OR;
          3'd7: op = BIN_AND;
        endcase
      end else if (insn[31:25] == 7'b0100000 && insn[14:12] == 3'd0) begin
        op = BIN_SUB;
      end else if (insn[31:25] == 7'b0100000 && insn[14:12] == 3'd5) begin
        op = BIN_SRA;
      end
    end else if (insn[6:0] == 7'b1101111) begin
      op = BIN_JAL;
    end else if (insn[6:0] == 7'b0100011 && insn[14:12] == 3'd0) begin
      op = BIN_SB;
    end else if (insn[6:0] == 7'b0100011 && insn[14:12] == 3'd1) begin
      op = BIN_SH;
    end else if (insn[6:0] == 7'b0100011 && insn[14:12] == 3'd2) begin
      op = BIN_SW;
    end
    return op;
  endfunction

  function automatic decoded_insn_t make_record(input logic [31:0] insn);
    decoded_insn_t rec;
    rec.valid     = 1'b1;
    rec.op        = classify(insn);
    rec.rd        = insn[11:7];
    rec.rs1       = insn[19:15];
    rec.rs2       = insn[24:20];
    rec.imm_neg   = insn[31];
    rec.writes_rd = (insn[6:0] == 7'b0110011 && rec.op != BIN_OTHER) || rec.op == BIN_JAL;
    return rec;
  endfunction

  // Expected event for a word, given the previous valid retirement
  function automatic cov_event_t expected_event(input logic [31:0] insn,
                                                input decoded_insn_t prev);
    decoded_insn_t cur;
    cov_event_t    e;
    logic          jal;
    logic          store;
    logic          rtype;
    logic          reads;
    cur   = make_record(insn);
    jal   = (cur.op == BIN_JAL);
    store = (insn[6:0] == 7'b0100011) && (cur.op != BIN_OTHER);
    rtype = cur.writes_rd && !jal;
    reads = rtype || store;
    e.valid    = 1'b1;
    e.op       = cur.op;
    e.zero_dst = (rtype || jal) && (cur.rd == 5'd0);
    e.same_src = reads && (cur.rs1 == cur.rs2);
    e.zero_src = reads && (cur.rs1 == 5'd0 || cur.rs2 == 5'd0);
    e.raw      = reads && prev.valid && prev.writes_rd &&
                 (prev.rd == cur.rs1 || prev.rd == cur.rs2);
    e.raw_op   = e.raw ? prev.op : BIN_OTHER;
    e.br_back  = jal && cur.imm_neg;
    e.br_fwd   = jal && !cur.imm_neg;
    return e;
  endfunction

  function automatic void bump(input cov_bin_e b);
    if (model_cnt[b] < CNT_MAX) begin
      model_cnt[b]++;
    end
  endfunction

  function automatic void count_event(input cov_event_t e);
    bump(e.op);
    if (e.zero_dst) bump(BIN_ZERO_DST);
    if (e.same_src) bump(BIN_SAME_SRC);
    if (e.zero_src) bump(BIN_ZERO_SRC);
    if (e.raw) bump(BIN_RAW);
    if (e.br_back) bump(BIN_BR_BACK);
    if (e.br_fwd) bump(BIN_BR_FWD);
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {7'h15, rs2, rs1, f3, 5'h0a, 7'b0100011};
  endfunction

  // Sign bit of the offset picks the jump direction
  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic back);
    return {back, 10'h010, 1'b0, 8'h00, rd, 7'b1101111};
  endfunction

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, act, exp);
      errors++;
    end
  endtask

  task automatic retire(input logic [31:0] insn);
    cov_event_t exp;
    @(posedge clk);
    retire_valid <= 1'b1;
    retire_insn  <= insn;
    exp = expected_event(insn, model_prev);
    exp_q.push_back(exp);
    cyc_q.push_back(cyc + 3);
    count_event(exp);
    model_prev = make_record(insn);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    retire_valid <= 1'b0;
    retire_insn  <= $random(seed);
  endtask

  task automatic read_counter(input cov_bin_e bin, input int exp);
    @(posedge clk);
    retire_valid <= 1'b0;
    cnt_sel      <= bin;
    @(negedge clk);
    check_value($sformatf("cnt_o[%s]", bin.name()), cnt, exp);
  endtask

  // Weighted mix over x0..x3 so hazards and zero fields come up often
  task automatic random_insn(output logic [31:0] insn);
    logic [31:0] r;
    logic [6:0]  f7;
    int          kind;
    r    = $random(seed);
    kind = $unsigned($random(seed)) % 10;
    f7   = (r[10:9] == 2'd2) ? 7'b0100000 : (r[10:9] == 2'd3) ? 7'b0000001 : 7'b0000000;
    if (kind < 4) begin
      insn = r_type(f7, r[8:6], {3'b0, r[1:0]}, {3'b0, r[3:2]}, {3'b0, r[5:4]});
    end else if (kind < 6) begin
      insn = j_type({3'b0, r[1:0]}, r[31]);
    end else if (kind < 8) begin
      insn = s_type({1'b0, r[7:6]}, {3'b0, r[3:2]}, {3'b0, r[5:4]});
    end else begin
      insn = {r[31:7], r[11] ? 7'b0010011 : 7'b0000011};
    end
  endtask

  // Event compare, sampled away from the driving edge
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!reset) begin
      if (cov_event.valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Event appeared at cycle %0d with no retirement pending", cyc);
          errors++;
        end else begin
          want_evt = exp_q.pop_front();
          want_cyc = cyc_q.pop_front();
          check_value("cov_event_o", cov_event, want_evt);
          check_value("cov_event_o cycle", cyc, want_cyc);
        end
      end else if (cov_event.valid !== 1'b0) begin
        $display("Event valid is unknown at cycle %0d", cyc);
        errors++;
      end else if (cyc_q.size() > 0 && cyc_q[0] <= cyc) begin
        $display("Expected event did not appear at cycle %0d", cyc);
        errors++;
        want_evt = exp_q.pop_front();
        want_cyc = cyc_q.pop_front();
      end
    end
  end

  always @(posedge clk) begin
    run_cycles = run_cycles + 1;
    if (run_cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      errors++;
      $display("Checks finished with %0d errors", errors);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] insn;
    int          n;
    retire_valid = 1'b0;
    retire_insn  = '0;
    cnt_sel      = BIN_ADD;
    reset        = 1'b1;
    model_prev   = '0;
    for (int b = 0; b < NUM_BINS; b++) begin
      model_cnt[b] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (int b = 0; b < NUM_BINS; b++) begin
      read_counter(cov_bin_e'(b), 0);
    end

    // All op classes back to back
    retire(r_type(7'h00, 3'd0, 5'd1, 5'd2, 5'd3));
    retire(r_type(7'h20, 3'd0, 5'd0, 5'd2, 5'd2));
    retire(r_type(7'h00, 3'd1, 5'd3, 5'd0, 5'd4));
    retire(r_type(7'h00, 3'd2, 5'd4, 5'd5, 5'd6));
    retire(r_type(7'h00, 3'd3, 5'd7, 5'd4, 5'd0));
    retire(r_type(7'h00, 3'd4, 5'd8, 5'd9, 5'd9));
    retire(r_type(7'h00, 3'd5, 5'd0, 5'd1, 5'd8));
    retire(r_type(7'h20, 3'd5, 5'd10, 5'd11, 5'd12));
    retire(r_type(7'h00, 3'd6, 5'd11, 5'd10, 5'd13));
    retire(r_type(7'h00, 3'd7, 5'd12, 5'd0, 5'd0));
    retire(j_type(5'd1, 1'b0));
    retire(j_type(5'd0, 1'b1));
    retire(s_type(3'd0, 5'd3, 5'd3));
    retire(s_type(3'd1, 5'd0, 5'd2));
    retire(s_type(3'd2, 5'd4, 5'd6));
    // M extension, store funct3 3 and ADDI
    retire(r_type(7'h01, 3'd0, 5'd2, 5'd3, 5'd4));
    retire(s_type(3'd3, 5'd1, 5'd1));
    retire({12'h001, 5'd0, 3'd0, 5'd4, 7'b0010011});
    idle_cycle();

    // RAW from ADD, from JAL across a gap, and none behind BIN_OTHER
    retire(r_type(7'h00, 3'd0, 5'd5, 5'd6, 5'd7));
    retire(s_type(3'd2, 5'd2, 5'd5));
    retire(j_type(5'd1, 1'b0));
    idle_cycle();
    idle_cycle();
    retire(r_type(7'h00, 3'd4, 5'd3, 5'd1, 5'd2));
    retire({12'h001, 5'd0, 3'd0, 5'd4, 7'b0010011});
    retire(r_type(7'h00, 3'd0, 5'd8, 5'd4, 5'd9));

    n = 0;
    while (n < RAND_RETIRES) begin
      if ($unsigned($random(seed)) % 10 < 7) begin
        random_insn(insn);
        retire(insn);
        n++;
      end else begin
        idle_cycle();
      end
    end
    repeat (4) idle_cycle();

    for (int b = 0; b < NUM_BINS; b++) begin
      read_counter(cov_bin_e'(b), model_cnt[b]);
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected events never appeared", exp_q.size());
      errors++;
    end
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
